// File: include/mmu_config.svh
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// tlb geometry
`define MMU_TLB_NUM 16

// address widths
`define MMU_VALEN 32
`define MMU_PALEN 32

// csr numbers of the translation controls
`define MMU_CSR_CRMD 14'h000
`define MMU_CSR_ASID 14'h018
`define MMU_CSR_DMW0 14'h180
`define MMU_CSR_DMW1 14'h181

`endif

// File: src/mmu_pkg.sv
`default_nettype none

`include "mmu_config.svh"

package mmu_pkg;

  typedef logic [`MMU_VALEN-1:0] vaddr_t;
  typedef logic [`MMU_PALEN-1:0] paddr_t;

  // 4 KB pages, one entry covers an even/odd pair
  typedef logic [18:0] vppn_t;
  typedef logic [19:0] ppn_t;
  typedef logic [9:0]  asid_t;
  typedef logic [1:0]  plv_t;
  typedef logic [2:0]  seg_t;

  localparam int TLB_IDX_W = $clog2(`MMU_TLB_NUM);
  typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

  typedef logic [2:0] fault_t;

  localparam fault_t FAULT_NONE    = 3'd0;
  localparam fault_t FAULT_REFILL  = 3'd1;
  localparam fault_t FAULT_INVALID = 3'd2;
  localparam fault_t FAULT_PRIV    = 3'd3;
  localparam fault_t FAULT_MODIFY  = 3'd4;

endpackage

`default_nettype wire

// File: src/csr_pkg.sv
`default_nettype none

package csr_pkg;

  typedef logic [13:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // crmd fields
  localparam int CRMD_PLV_LO = 0;
  localparam int CRMD_PLV_HI = 1;
  localparam int CRMD_DA     = 3;
  localparam int CRMD_PG     = 4;

  // dmw fields
  localparam int DMW_PLV0    = 0;
  localparam int DMW_PLV3    = 3;
  localparam int DMW_PSEG_LO = 25;
  localparam int DMW_PSEG_HI = 27;
  localparam int DMW_VSEG_LO = 29;
  localparam int DMW_VSEG_HI = 31;

endpackage

`default_nettype wire

// File: src/mmu_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module mmu_csr_regs (
  input  wire                    aclk,
  input  wire                    arst_n,
  input  wire                    csr_we,
  input  wire csr_pkg::csr_addr_t csr_waddr,
  input  wire csr_pkg::csr_data_t csr_wdata,
  output logic                   da,
  output logic                   pg,
  output mmu_pkg::plv_t          cur_plv,
  output mmu_pkg::asid_t         cur_asid,
  output mmu_pkg::seg_t          dmw0_vseg,
  output mmu_pkg::seg_t          dmw0_pseg,
  output logic                   dmw0_plv0,
  output logic                   dmw0_plv3,
  output mmu_pkg::seg_t          dmw1_vseg,
  output mmu_pkg::seg_t          dmw1_pseg,
  output logic                   dmw1_plv0,
  output logic                   dmw1_plv3
);
  import mmu_pkg::*;
  import csr_pkg::*;

  // crmd, comes out of reset in direct mode at plv0
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      da      <= 1'b1;
      pg      <= 1'b0;
      cur_plv <= '0;
    end else if (csr_we && csr_waddr == `MMU_CSR_CRMD) begin
      da      <= csr_wdata[CRMD_DA];
      pg      <= csr_wdata[CRMD_PG];
      cur_plv <= csr_wdata[CRMD_PLV_HI:CRMD_PLV_LO];
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      cur_asid <= '0;
    end else if (csr_we && csr_waddr == `MMU_CSR_ASID) begin
      cur_asid <= asid_t'(csr_wdata);
    end
  end

  // both windows start disabled
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      dmw0_vseg <= '0;
      dmw0_pseg <= '0;
      dmw0_plv0 <= 1'b0;
      dmw0_plv3 <= 1'b0;
    end else if (csr_we && csr_waddr == `MMU_CSR_DMW0) begin
      dmw0_vseg <= csr_wdata[DMW_VSEG_HI:DMW_VSEG_LO];
      dmw0_pseg <= csr_wdata[DMW_PSEG_HI:DMW_PSEG_LO];
      dmw0_plv0 <= csr_wdata[DMW_PLV0];
      dmw0_plv3 <= csr_wdata[DMW_PLV3];
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      dmw1_vseg <= '0;
      dmw1_pseg <= '0;
      dmw1_plv0 <= 1'b0;
      dmw1_plv3 <= 1'b0;
    end else if (csr_we && csr_waddr == `MMU_CSR_DMW1) begin
      dmw1_vseg <= csr_wdata[DMW_VSEG_HI:DMW_VSEG_LO];
      dmw1_pseg <= csr_wdata[DMW_PSEG_HI:DMW_PSEG_LO];
      dmw1_plv0 <= csr_wdata[DMW_PLV0];
      dmw1_plv3 <= csr_wdata[DMW_PLV3];
    end
  end

endmodule

`default_nettype wire

// File: src/tlb_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module tlb_array (
  input  wire                   aclk,
  input  wire                   arst_n,
  input  wire                   tlb_we,
  input  wire mmu_pkg::tlb_idx_t tlb_windex,
  input  wire                   w_e,
  input  wire mmu_pkg::vppn_t   w_vppn,
  input  wire mmu_pkg::asid_t   w_asid,
  input  wire                   w_g,
  input  wire mmu_pkg::ppn_t    w_ppn0,
  input  wire mmu_pkg::plv_t    w_plv0,
  input  wire                   w_d0,
  input  wire                   w_v0,
  input  wire mmu_pkg::ppn_t    w_ppn1,
  input  wire mmu_pkg::plv_t    w_plv1,
  input  wire                   w_d1,
  input  wire                   w_v1,
  input  wire                   inv_valid,
  input  wire [4:0]             inv_op,
  input  wire mmu_pkg::asid_t   cur_asid,
  input  wire mmu_pkg::vppn_t   s_vppn,
  input  wire                   s_odd,
  output logic                  s_found,
  output mmu_pkg::ppn_t         s_ppn,
  output mmu_pkg::plv_t         s_plv,
  output logic                  s_d,
  output logic                  s_v
);
  import mmu_pkg::*;

  logic [`MMU_TLB_NUM-1:0] e_q;
  logic [`MMU_TLB_NUM-1:0] g_q;
  vppn_t                   vppn_q [`MMU_TLB_NUM];
  asid_t                   asid_q [`MMU_TLB_NUM];
  ppn_t                    ppn0_q [`MMU_TLB_NUM];
  plv_t                    plv0_q [`MMU_TLB_NUM];
  logic [`MMU_TLB_NUM-1:0] d0_q;
  logic [`MMU_TLB_NUM-1:0] v0_q;
  ppn_t                    ppn1_q [`MMU_TLB_NUM];
  plv_t                    plv1_q [`MMU_TLB_NUM];
  logic [`MMU_TLB_NUM-1:0] d1_q;
  logic [`MMU_TLB_NUM-1:0] v1_q;

  logic [`MMU_TLB_NUM-1:0] inv_clear;
  logic [`MMU_TLB_NUM-1:0] hit;

  // entries named by the invtlb op
  always_comb begin
    for (int i = 0; i < `MMU_TLB_NUM; i++) begin
      case (inv_op)
        5'd0, 5'd1: inv_clear[i] = 1'b1;
        5'd2:       inv_clear[i] = g_q[i];
        5'd3:       inv_clear[i] = !g_q[i];
        5'd4:       inv_clear[i] = !g_q[i] && asid_q[i] == cur_asid;
        default:    inv_clear[i] = 1'b0;
      endcase
    end
  end

  // an invalidation strobe blocks a write in the same cycle
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      e_q <= '0;
    end else if (inv_valid) begin
      for (int i = 0; i < `MMU_TLB_NUM; i++) begin
        if (inv_clear[i]) begin
          e_q[i] <= 1'b0;
        end
      end
    end else if (tlb_we) begin
      e_q[tlb_windex] <= w_e;
    end
  end

  always_ff @(posedge aclk) begin
    if (tlb_we && !inv_valid) begin
      g_q[tlb_windex]    <= w_g;
      vppn_q[tlb_windex] <= w_vppn;
      asid_q[tlb_windex] <= w_asid;
      ppn0_q[tlb_windex] <= w_ppn0;
      plv0_q[tlb_windex] <= w_plv0;
      d0_q[tlb_windex]   <= w_d0;
      v0_q[tlb_windex]   <= w_v0;
      ppn1_q[tlb_windex] <= w_ppn1;
      plv1_q[tlb_windex] <= w_plv1;
      d1_q[tlb_windex]   <= w_d1;
      v1_q[tlb_windex]   <= w_v1;
    end
  end

  // parallel compare, global entries ignore the asid
  always_comb begin
    for (int i = 0; i < `MMU_TLB_NUM; i++) begin
      hit[i] = e_q[i] && vppn_q[i] == s_vppn && (g_q[i] || asid_q[i] == cur_asid);
    end
  end

  // va bit 12 picks the odd half
  always_comb begin
    s_found = |hit;
    s_ppn   = '0;
    s_plv   = '0;
    s_d     = 1'b0;
    s_v     = 1'b0;
    for (int i = 0; i < `MMU_TLB_NUM; i++) begin
      if (hit[i]) begin
        s_ppn = s_odd ? ppn1_q[i] : ppn0_q[i];
        s_plv = s_odd ? plv1_q[i] : plv0_q[i];
        s_d   = s_odd ? d1_q[i] : d0_q[i];
        s_v   = s_odd ? v1_q[i] : v0_q[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/addr_translate.sv
`timescale 1ns/1ps
`default_nettype none

module addr_translate (
  input  wire                 aclk,
  input  wire                 arst_n,
  input  wire                 xlat_req,
  input  wire mmu_pkg::vaddr_t xlat_va,
  input  wire                 xlat_store,
  input  wire                 da,
  input  wire                 pg,
  input  wire mmu_pkg::plv_t  cur_plv,
  input  wire mmu_pkg::seg_t  dmw0_vseg,
  input  wire mmu_pkg::seg_t  dmw0_pseg,
  input  wire                 dmw0_plv0,
  input  wire                 dmw0_plv3,
  input  wire mmu_pkg::seg_t  dmw1_vseg,
  input  wire mmu_pkg::seg_t  dmw1_pseg,
  input  wire                 dmw1_plv0,
  input  wire                 dmw1_plv3,
  input  wire                 s_found,
  input  wire mmu_pkg::ppn_t  s_ppn,
  input  wire mmu_pkg::plv_t  s_plv,
  input  wire                 s_d,
  input  wire                 s_v,
  output mmu_pkg::vppn_t      s_vppn,
  output logic                s_odd,
  output logic                xlat_done,
  output mmu_pkg::paddr_t     xlat_pa,
  output mmu_pkg::fault_t     xlat_fault
);
  import mmu_pkg::*;

  logic   mapped;
  logic   dmw0_hit;
  logic   dmw1_hit;
  paddr_t pa_nxt;
  fault_t fault_nxt;

  // window enable bits only exist for plv0 and plv3
  function automatic logic window_hit(seg_t va_seg, seg_t vseg, logic en0, logic en3,
                                      plv_t plv);
    return va_seg == vseg && ((plv == 2'd0 && en0) || (plv == 2'd3 && en3));
  endfunction

  assign s_vppn = xlat_va[31:13];
  assign s_odd  = xlat_va[12];

  assign mapped   = !da && pg;
  assign dmw0_hit = window_hit(xlat_va[31:29], dmw0_vseg, dmw0_plv0, dmw0_plv3, cur_plv);
  assign dmw1_hit = window_hit(xlat_va[31:29], dmw1_vseg, dmw1_plv0, dmw1_plv3, cur_plv);

  // dmw0 before dmw1 before tlb; faults checked in priority order
  always_comb begin
    pa_nxt    = '0;
    fault_nxt = FAULT_NONE;
    if (!mapped) begin
      pa_nxt = paddr_t'(xlat_va);
    end else if (dmw0_hit) begin
      pa_nxt = {dmw0_pseg, xlat_va[28:0]};
    end else if (dmw1_hit) begin
      pa_nxt = {dmw1_pseg, xlat_va[28:0]};
    end else if (!s_found) begin
      fault_nxt = FAULT_REFILL;
    end else if (!s_v) begin
      fault_nxt = FAULT_INVALID;
    end else if (cur_plv > s_plv) begin
      fault_nxt = FAULT_PRIV;
    end else if (xlat_store && !s_d) begin
      fault_nxt = FAULT_MODIFY;
    end else begin
      pa_nxt = {s_ppn, xlat_va[11:0]};
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      xlat_done <= 1'b0;
    end else begin
      xlat_done <= xlat_req;
    end
  end

  always_ff @(posedge aclk) begin
    if (xlat_req) begin
      xlat_pa    <= pa_nxt;
      xlat_fault <= fault_nxt;
    end
  end

endmodule

`default_nettype wire

// File: src/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module mmu_top (
  input  wire                            aclk,
  input  wire                            arst_n,

  // csr write
  input  wire                            csr_we,
  input  wire csr_pkg::csr_addr_t        csr_waddr,
  input  wire csr_pkg::csr_data_t        csr_wdata,

  // tlb entry write
  input  wire                            tlb_we,
  input  wire [$clog2(`MMU_TLB_NUM)-1:0] tlb_windex,
  input  wire                            w_e,
  input  wire [18:0]                     w_vppn,
  input  wire [9:0]                      w_asid,
  input  wire                            w_g,
  input  wire [19:0]                     w_ppn0,
  input  wire [1:0]                      w_plv0,
  input  wire                            w_d0,
  input  wire                            w_v0,
  input  wire [19:0]                     w_ppn1,
  input  wire [1:0]                      w_plv1,
  input  wire                            w_d1,
  input  wire                            w_v1,

  // invtlb
  input  wire                            inv_valid,
  input  wire [4:0]                      inv_op,

  // translation
  input  wire                            xlat_req,
  input  wire [`MMU_VALEN-1:0]           xlat_va,
  input  wire                            xlat_store,
  output wire                            xlat_done,
  output wire [`MMU_PALEN-1:0]           xlat_pa,
  output wire [2:0]                      xlat_fault
);

  wire        da;
  wire        pg;
  wire [1:0]  cur_plv;
  wire [9:0]  cur_asid;
  wire [2:0]  dmw0_vseg;
  wire [2:0]  dmw0_pseg;
  wire        dmw0_plv0;
  wire        dmw0_plv3;
  wire [2:0]  dmw1_vseg;
  wire [2:0]  dmw1_pseg;
  wire        dmw1_plv0;
  wire        dmw1_plv3;

  // search port
  wire [18:0] s_vppn;
  wire        s_odd;
  wire        s_found;
  wire [19:0] s_ppn;
  wire [1:0]  s_plv;
  wire        s_d;
  wire        s_v;

  mmu_csr_regs u_csr_regs (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .csr_we    (csr_we),
    .csr_waddr (csr_waddr),
    .csr_wdata (csr_wdata),
    .da        (da),
    .pg        (pg),
    .cur_plv   (cur_plv),
    .cur_asid  (cur_asid),
    .dmw0_vseg (dmw0_vseg),
    .dmw0_pseg (dmw0_pseg),
    .dmw0_plv0 (dmw0_plv0),
    .dmw0_plv3 (dmw0_plv3),
    .dmw1_vseg (dmw1_vseg),
    .dmw1_pseg (dmw1_pseg),
    .dmw1_plv0 (dmw1_plv0),
    .dmw1_plv3 (dmw1_plv3)
  );

  tlb_array u_tlb_array (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .tlb_we     (tlb_we),
    .tlb_windex (tlb_windex),
    .w_e        (w_e),
    .w_vppn     (w_vppn),
    .w_asid     (w_asid),
    .w_g        (w_g),
    .w_ppn0     (w_ppn0),
    .w_plv0     (w_plv0),
    .w_d0       (w_d0),
    .w_v0       (w_v0),
    .w_ppn1     (w_ppn1),
    .w_plv1     (w_plv1),
    .w_d1       (w_d1),
    .w_v1       (w_v1),
    .inv_valid  (inv_valid),
    .inv_op     (inv_op),
    .cur_asid   (cur_asid),
    .s_vppn     (s_vppn),
    .s_odd      (s_odd),
    .s_found    (s_found),
    .s_ppn      (s_ppn),
    .s_plv      (s_plv),
    .s_d        (s_d),
    .s_v        (s_v)
  );

  addr_translate u_addr_translate (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .xlat_req   (xlat_req),
    .xlat_va    (xlat_va),
    .xlat_store (xlat_store),
    .da         (da),
    .pg         (pg),
    .cur_plv    (cur_plv),
    .dmw0_vseg  (dmw0_vseg),
    .dmw0_pseg  (dmw0_pseg),
    .dmw0_plv0  (dmw0_plv0),
    .dmw0_plv3  (dmw0_plv3),
    .dmw1_vseg  (dmw1_vseg),
    .dmw1_pseg  (dmw1_pseg),
    .dmw1_plv0  (dmw1_plv0),
    .dmw1_plv3  (dmw1_plv3),
    .s_found    (s_found),
    .s_ppn      (s_ppn),
    .s_plv      (s_plv),
    .s_d        (s_d),
    .s_v        (s_v),
    .s_vppn     (s_vppn),
    .s_odd      (s_odd),
    .xlat_done  (xlat_done),
    .xlat_pa    (xlat_pa),
    .xlat_fault (xlat_fault)
  );

endmodule

`default_nettype wire

// File: tb/mmu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_assertions (
  input wire                  aclk,
  input wire                  arst_n,
  input wire                  xlat_req,
  input wire                  da,
  input wire                  xlat_done,
  input wire mmu_pkg::fault_t xlat_fault
);
  import mmu_pkg::*;

  // done is exactly one cycle behind the request
  assert property (@(posedge aclk) disable iff (!arst_n) xlat_req |=> xlat_done)
    else $error("xlat_done missing one cycle after xlat_req");

  assert property (@(posedge aclk) disable iff (!arst_n) xlat_done |-> $past(xlat_req))
    else $error("xlat_done without a request in the previous cycle");

  // direct mode never faults
  assert property (@(posedge aclk) disable iff (!arst_n)
    (xlat_req && da) |=> xlat_fault == FAULT_NONE)
    else $error("fault reported in direct address mode");

endmodule

bind addr_translate mmu_assertions i_assertions (
  .aclk       (aclk),
  .arst_n     (arst_n),
  .xlat_req   (xlat_req),
  .da         (da),
  .xlat_done  (xlat_done),
  .xlat_fault (xlat_fault)
);

`default_nettype wire

// File: tb/mmu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module mmu_checker (
  input  wire                     aclk,
  input  wire                     arst_n,
  input  wire                     csr_we,
  input  wire csr_pkg::csr_addr_t csr_waddr,
  input  wire csr_pkg::csr_data_t csr_wdata,
  input  wire                     tlb_we,
  input  wire mmu_pkg::tlb_idx_t  tlb_windex,
  input  wire                     w_e,
  input  wire                     w_g,
  input  wire                     w_d0,
  input  wire                     w_v0,
  input  wire                     w_d1,
  input  wire                     w_v1,
  input  wire mmu_pkg::vppn_t     w_vppn,
  input  wire mmu_pkg::asid_t     w_asid,
  input  wire mmu_pkg::ppn_t      w_ppn0,
  input  wire mmu_pkg::ppn_t      w_ppn1,
  input  wire mmu_pkg::plv_t      w_plv0,
  input  wire mmu_pkg::plv_t      w_plv1,
  input  wire                     inv_valid,
  input  wire [4:0]               inv_op,
  input  wire                     xlat_req,
  input  wire mmu_pkg::vaddr_t    xlat_va,
  input  wire                     xlat_store,
  input  wire                     xlat_done,
  input  wire mmu_pkg::paddr_t    xlat_pa,
  input  wire mmu_pkg::fault_t    xlat_fault,
  output int                      err_count,
  output int                      check_count,
  output int                      pending
);
  import mmu_pkg::*;
  import csr_pkg::*;

  csr_data_t               m_crmd;
  csr_data_t               m_asid;
  csr_data_t               m_dmw0;
  csr_data_t               m_dmw1;
  logic [`MMU_TLB_NUM-1:0] m_e;
  logic [`MMU_TLB_NUM-1:0] m_g;
  vppn_t                   m_vppn [`MMU_TLB_NUM];
  asid_t                   m_asidv [`MMU_TLB_NUM];
  ppn_t                    m_ppn [`MMU_TLB_NUM][2];
  // per half {plv, d, v}
  logic [3:0]              m_attr [`MMU_TLB_NUM][2];

  logic [34:0] exp_q [$];
  vaddr_t      va_q [$];

  function automatic logic window_on(csr_data_t dmw, vaddr_t va, plv_t plv);
    return dmw[DMW_VSEG_HI:DMW_VSEG_LO] == va[31:29] &&
      ((plv == 2'd0 && dmw[DMW_PLV0]) || (plv == 2'd3 && dmw[DMW_PLV3]));
  endfunction

  // expected {fault, pa} from the modeled state
  function automatic logic [34:0] ref_xlat(vaddr_t va, logic store);
    plv_t       plv;
    int         hit;
    logic [3:0] attr;
    plv = m_crmd[CRMD_PLV_HI:CRMD_PLV_LO];
    hit = -1;
    if (m_crmd[CRMD_DA] || !m_crmd[CRMD_PG]) return {FAULT_NONE, va};
    if (window_on(m_dmw0, va, plv)) return {FAULT_NONE, m_dmw0[27:25], va[28:0]};
    if (window_on(m_dmw1, va, plv)) return {FAULT_NONE, m_dmw1[27:25], va[28:0]};
    for (int i = 0; i < `MMU_TLB_NUM; i++) begin
      if (m_e[i] && m_vppn[i] == va[31:13] && (m_g[i] || m_asidv[i] == m_asid[9:0])) begin
        hit = i;
      end
    end
    if (hit < 0) return {FAULT_REFILL, 32'd0};
    attr = m_attr[hit][va[12]];
    if (!attr[0]) return {FAULT_INVALID, 32'd0};
    if (plv > attr[3:2]) return {FAULT_PRIV, 32'd0};
    if (store && !attr[1]) return {FAULT_MODIFY, 32'd0};
    return {FAULT_NONE, m_ppn[hit][va[12]], va[11:0]};
  endfunction

  always @(posedge aclk) begin
    logic [34:0] exp;
    vaddr_t      va;
    if (!arst_n) begin
      m_crmd      = 32'h0000_0008;
      m_asid      = '0;
      m_dmw0      = '0;
      m_dmw1      = '0;
      m_e         = '0;
      err_count   = 0;
      check_count = 0;
      exp_q.delete();
      va_q.delete();
    end else begin
      if (xlat_done) begin
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: xlat_done came without a pending request", $time);
          err_count++;
        end else begin
          exp = exp_q.pop_front();
          va  = va_q.pop_front();
          check_count++;
          if (xlat_fault !== exp[34:32]) begin
            $display("FAILED at %0t: xlat_fault va=%h expected %0d got %0d",
                     $time, va, exp[34:32], xlat_fault);
            err_count++;
          end
          if (xlat_pa !== exp[31:0]) begin
            $display("FAILED at %0t: xlat_pa va=%h expected %h got %h",
                     $time, va, exp[31:0], xlat_pa);
            err_count++;
          end
        end
      end
      // anything still queued has missed its one-cycle answer
      while (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        va  = va_q.pop_front();
        $display("ERROR at %0t: request for va %h got no xlat_done", $time, va);
        err_count++;
      end
      if (xlat_req) begin
        exp_q.push_back(ref_xlat(xlat_va, xlat_store));
        va_q.push_back(xlat_va);
      end
      if (inv_valid) begin
        for (int i = 0; i < `MMU_TLB_NUM; i++) begin
          case (inv_op)
            5'd0, 5'd1: m_e[i] = 1'b0;
            5'd2: if (m_g[i]) m_e[i] = 1'b0;
            5'd3: if (!m_g[i]) m_e[i] = 1'b0;
            5'd4: if (!m_g[i] && m_asidv[i] == m_asid[9:0]) m_e[i] = 1'b0;
            default: ;
          endcase
        end
      end else if (tlb_we) begin
        m_e[tlb_windex]       = w_e;
        m_g[tlb_windex]       = w_g;
        m_vppn[tlb_windex]    = w_vppn;
        m_asidv[tlb_windex]   = w_asid;
        m_ppn[tlb_windex][0]  = w_ppn0;
        m_ppn[tlb_windex][1]  = w_ppn1;
        m_attr[tlb_windex][0] = {w_plv0, w_d0, w_v0};
        m_attr[tlb_windex][1] = {w_plv1, w_d1, w_v1};
      end
      if (csr_we) begin
        case (csr_waddr)
          `MMU_CSR_CRMD: m_crmd = csr_wdata;
          `MMU_CSR_ASID: m_asid = csr_wdata;
          `MMU_CSR_DMW0: m_dmw0 = csr_wdata;
          `MMU_CSR_DMW1: m_dmw1 = csr_wdata;
          default: ;
        endcase
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

// File: tb/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module mmu_tb;
  import mmu_pkg::*;
  import csr_pkg::*;

  logic      aclk;
  logic      arst_n;
  logic      csr_we;
  csr_addr_t csr_waddr;
  csr_data_t csr_wdata;
  logic      tlb_we;
  tlb_idx_t  tlb_windex;
  logic      w_e;
  logic      w_g;
  logic      w_d0;
  logic      w_v0;
  logic      w_d1;
  logic      w_v1;
  vppn_t     w_vppn;
  asid_t     w_asid;
  ppn_t      w_ppn0;
  ppn_t      w_ppn1;
  plv_t      w_plv0;
  plv_t      w_plv1;
  logic      inv_valid;
  logic [4:0] inv_op;
  logic      xlat_req;
  vaddr_t    xlat_va;
  logic      xlat_store;
  logic      xlat_done;
  paddr_t    xlat_pa;
  fault_t    xlat_fault;
  int        err_count;
  int        check_count;
  int        pending;

  integer seed;
  int     tests_run;
  int     tests_failed;
  int     err_mark;

  mmu_top i_dut (.*);

  mmu_checker i_chk (.*);

  initial aclk = 1'b0;
  always #20 aclk = ~aclk;

  function automatic csr_data_t dmw_word(seg_t vseg, seg_t pseg, logic en0, logic en3);
    return {vseg, 1'b0, pseg, 21'd0, en3, 2'b00, en0};
  endfunction

  task automatic csr_wr(input csr_addr_t a, input csr_data_t d);
    @(posedge aclk);
    csr_we    <= 1'b1;
    csr_waddr <= a;
    csr_wdata <= d;
    @(posedge aclk);
    csr_we    <= 1'b0;
  endtask

  // attributes given as {plv, d, v}
  task automatic tlb_wr(input tlb_idx_t idx, input vppn_t vppn, input asid_t asid,
                        input logic g, input ppn_t ppn0, input logic [3:0] a0,
                        input ppn_t ppn1, input logic [3:0] a1);
    @(posedge aclk);
    tlb_we     <= 1'b1;
    tlb_windex <= idx;
    w_e        <= 1'b1;
    w_vppn     <= vppn;
    w_asid     <= asid;
    w_g        <= g;
    w_ppn0     <= ppn0;
    {w_plv0, w_d0, w_v0} <= a0;
    w_ppn1     <= ppn1;
    {w_plv1, w_d1, w_v1} <= a1;
    @(posedge aclk);
    tlb_we     <= 1'b0;
  endtask

  task automatic inv_tlb(input logic [4:0] op);
    @(posedge aclk);
    inv_valid <= 1'b1;
    inv_op    <= op;
    @(posedge aclk);
    inv_valid <= 1'b0;
  endtask

  task automatic xlat(input vaddr_t va, input logic store);
    @(posedge aclk);
    xlat_req   <= 1'b1;
    xlat_va    <= va;
    xlat_store <= store;
    @(posedge aclk);
    xlat_req   <= 1'b0;
  endtask

  task automatic end_test(input string name);
    int waited;
    waited = 0;
    @(negedge aclk);
    while ((pending != 0 || xlat_req) && waited < 20) begin
      @(negedge aclk);
      waited++;
    end
    tests_run++;
    if (waited == 20) begin
      $display("ERROR: translations of test %s did not complete in time", name);
      tests_failed++;
    end else if (err_count != err_mark) begin
      $display("test %-8s failed with %0d errors", name, err_count - err_mark);
      tests_failed++;
    end else begin
      $display("test %-8s passed", name);
    end
    err_mark = err_count;
  endtask

  initial begin
    integer     r;
    integer     r2;
    integer     r3;
    integer     r4;
    logic [4:0] op;
    seed         = 32'h8e2a_2f2f;
    tests_run    = 0;
    tests_failed = 0;
    err_mark     = 0;
    arst_n     = 1'b0;
    csr_we     = 1'b0;
    csr_waddr  = '0;
    csr_wdata  = '0;
    tlb_we     = 1'b0;
    tlb_windex = '0;
    w_e        = 1'b0;
    w_g        = 1'b0;
    w_d0       = 1'b0;
    w_v0       = 1'b0;
    w_d1       = 1'b0;
    w_v1       = 1'b0;
    w_vppn     = '0;
    w_asid     = '0;
    w_ppn0     = '0;
    w_ppn1     = '0;
    w_plv0     = '0;
    w_plv1     = '0;
    inv_valid  = 1'b0;
    inv_op     = '0;
    xlat_req   = 1'b0;
    xlat_va    = '0;
    xlat_store = 1'b0;
    repeat (5) @(posedge aclk);
    arst_n <= 1'b1;

    repeat (8) begin
      r = $random(seed);
      xlat(r, r[0]);
    end
    end_test("direct");

    // mapped at plv0 with dmw1 only enabled for plv3
    csr_wr(`MMU_CSR_CRMD, 32'h10);
    csr_wr(`MMU_CSR_DMW0, dmw_word(3'd5, 3'd1, 1'b1, 1'b0));
    csr_wr(`MMU_CSR_DMW1, dmw_word(3'd4, 3'd2, 1'b0, 1'b1));
    xlat(32'hA000_1234, 1'b0);
    xlat(32'h8000_5678, 1'b0);
    csr_wr(`MMU_CSR_CRMD, 32'h13);
    xlat(32'hA000_1234, 1'b0);
    xlat(32'h8000_5678, 1'b1);
    csr_wr(`MMU_CSR_CRMD, 32'h10);
    csr_wr(`MMU_CSR_DMW1, dmw_word(3'd5, 3'd2, 1'b1, 1'b1));
    xlat(32'hBFFF_FFFC, 1'b1);
    csr_wr(`MMU_CSR_DMW0, 32'h0);
    csr_wr(`MMU_CSR_DMW1, 32'h0);
    end_test("dmw");

    csr_wr(`MMU_CSR_ASID, 32'd5);
    tlb_wr(4'd1, 19'h00100, 10'd5, 1'b0, 20'hAAAAA, 4'b1111, 20'hBBBBB, 4'b1111);
    tlb_wr(4'd2, 19'h00200, 10'd9, 1'b1, 20'h12345, 4'b1111, 20'h54321, 4'b1011);
    xlat({19'h00100, 1'b0, 12'h123}, 1'b0);
    xlat({19'h00100, 1'b1, 12'h456}, 1'b1);
    xlat({19'h00200, 1'b0, 12'h789}, 1'b0);
    xlat({19'h00200, 1'b1, 12'hABC}, 1'b1);
    csr_wr(`MMU_CSR_ASID, 32'd7);
    xlat({19'h00100, 1'b0, 12'h123}, 1'b0);
    xlat({19'h00200, 1'b1, 12'hABC}, 1'b0);
    csr_wr(`MMU_CSR_ASID, 32'd5);
    end_test("tlb");

    // even half invalid while odd half is plv0 and clean
    tlb_wr(4'd3, 19'h00300, 10'd5, 1'b0, 20'h11111, 4'b0010, 20'h22222, 4'b0001);
    csr_wr(`MMU_CSR_CRMD, 32'h13);
    xlat({19'h00300, 1'b0, 12'h010}, 1'b1);
    xlat({19'h00300, 1'b1, 12'h020}, 1'b1);
    csr_wr(`MMU_CSR_CRMD, 32'h10);
    xlat({19'h00300, 1'b1, 12'h030}, 1'b0);
    xlat({19'h00300, 1'b1, 12'h040}, 1'b1);
    xlat({19'h7FFFF, 1'b0, 12'h050}, 1'b0);
    end_test("faults");

    for (op = 5'd0; op <= 5'd4; op++) begin
      tlb_wr(4'd4, 19'h00400, 10'd5, 1'b1, 20'h40000, 4'b1111, 20'h40001, 4'b1111);
      tlb_wr(4'd5, 19'h00500, 10'd5, 1'b0, 20'h50000, 4'b1111, 20'h50001, 4'b1111);
      tlb_wr(4'd6, 19'h00600, 10'd6, 1'b0, 20'h60000, 4'b1111, 20'h60001, 4'b1111);
      inv_tlb(op);
      xlat({19'h00400, 1'b0, 12'h004}, 1'b0);
      xlat({19'h00500, 1'b0, 12'h005}, 1'b0);
      // entry 6 only matches under its own asid
      csr_wr(`MMU_CSR_ASID, 32'd6);
      xlat({19'h00600, 1'b1, 12'h006}, 1'b0);
      csr_wr(`MMU_CSR_ASID, 32'd5);
    end
    end_test("invtlb");

    // entry vppn carries its index so no two entries can match one page
    inv_tlb(5'd0);
    repeat (400) begin
      @(posedge aclk);
      r  = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      r4 = $random(seed);
      xlat_req   <= r[0] | r[1];
      xlat_store <= r[2];
      xlat_va    <= r[3] ? r2 : {12'h000, r2[22:16], r2[12:0]};
      tlb_we     <= r[7:5] == 3'd0;
      tlb_windex <= r3[3:0];
      w_e        <= r3[4] | r3[5];
      w_g        <= r3[6];
      w_vppn     <= {12'h000, r3[9:7], r3[3:0]};
      w_asid     <= {8'h00, r3[11:10]};
      w_ppn0     <= r4[19:0];
      w_ppn1     <= {r4[31:20], r3[19:12]};
      {w_plv0, w_d0, w_v0} <= r3[23:20];
      {w_plv1, w_d1, w_v1} <= r3[27:24];
      inv_valid  <= r[11:8] == 4'd0;
      inv_op     <= {2'b00, r[14:12]};
      csr_we     <= r[17:15] == 3'd0;
      case (r[19:18])
        2'd0: begin
          csr_waddr <= `MMU_CSR_CRMD;
          csr_wdata <= {27'd0, 1'b1, r4[0] & r4[1], 1'b0, r4[3:2]};
        end
        2'd1: begin
          csr_waddr <= `MMU_CSR_ASID;
          csr_wdata <= {r4[31:10], 8'h00, r4[1:0]};
        end
        2'd2: begin
          csr_waddr <= `MMU_CSR_DMW0;
          csr_wdata <= dmw_word({2'b00, r4[4]}, r4[7:5], r4[8], r4[9]);
        end
        default: begin
          csr_waddr <= r4[10] ? `MMU_CSR_DMW1 : 14'h3ff;
          csr_wdata <= dmw_word({2'b00, r4[11]}, r4[14:12], r4[15], r4[16]);
        end
      endcase
    end
    @(posedge aclk);
    xlat_req  <= 1'b0;
    tlb_we    <= 1'b0;
    inv_valid <= 1'b0;
    csr_we    <= 1'b0;
    end_test("random");

    $display("%0d tests, %0d failed, %0d translations checked, %0d errors",
             tests_run, tests_failed, check_count, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mmu_top.f
+incdir+include
src/mmu_pkg.sv
src/csr_pkg.sv
src/mmu_csr_regs.sv
src/tlb_array.sv
src/addr_translate.sv
src/mmu_top.sv
tb/mmu_assertions.sv
tb/mmu_checker.sv
tb/mmu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mmu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mmu_top.f --top-module mmu_tb \
  -o mmu_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/mmu_sim > sim.log 2>&1
cat sim.log

grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
